/* hd44780.f */
rtl/hd44780_pkg.sv
rtl/hd_button_arm.sv
rtl/hd_byte_sender.sv
rtl/hd_nybble_sender.sv
rtl/hd_alive_blink.sv
rtl/hd44780_top.sv
dv/hd44780_tb.sv

/* Makefile */
# Verilator build of the HD44780 write path testbench

TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = hd44780_tb
FILELIST = hd44780.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# the simulator exits non-zero on $fatal, so make fails with it
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* dv/hd44780_tb.sv */
`timescale 1ns/1ps

module hd44780_tb import hd44780_pkg::*; ();

    localparam int TAS           = DEF_TAS;
    localparam int PWEH          = DEF_PWEH;
    localparam int TCYCE         = DEF_TCYCE;
    localparam int BLINK_BITS    = 8;               // small so the leds move in a short run
    localparam int NUM_BYTES     = 20;
    localparam int BYTE_TIMEOUT  = 4 * TCYCE;       // a byte needs about 2*TCYCE
    localparam int ARM_TIMEOUT   = 10;
    localparam int BLINK_TIMEOUT = 300;
    localparam logic [31:0] SEED = 32'hd180_3615;

    logic      clk = 1'b0;
    logic      i_reset;
    logic      i_button_n;
    logic      i_stb;
    logic      i_rs;
    lcd_byte_u i_byte;
    logic      o_busy;
    logic      o_lcd_rs;
    logic      o_lcd_e;
    nybble_t   o_lcd_data;
    logic      o_logan_strobe;
    logic      o_led_r;
    logic      o_led_g;
    logic      o_led_b;
    logic      o_led0;
    logic      o_led1;
    logic      o_led2;
    logic      o_led3;

    logic [31:0] lfsr;
    logic [4:0]  exp_q[$];                          // expected {rs, nybble} in send order
    logic [4:0]  cap_q[$];                          // captured {rs, nybble} for each enable pulse
    int          checked = 0;                       // pulses already compared
    int          cycle = 0;
    int          rise_cycle = 0;
    logic        prev_e = 1'b0;
    logic [2:0]  prev_rgb = 3'b000;
    logic [2:0]  rgb_seen = 3'b000;                 // rgb outputs seen lit at least once
    logic        held_rs;
    nybble_t     held_data;

    always #4 clk = ~clk;                           // 8 ns period

    hd44780_top #(
        .TAS        (TAS),
        .PWEH       (PWEH),
        .TCYCE      (TCYCE),
        .CNT_BITS   (DEF_CNT_BITS),
        .BLINK_BITS (BLINK_BITS),
        .PWM_BITS   (DEF_PWM_BITS)
    ) dut_i (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_button_n     (i_button_n),
        .i_stb          (i_stb),
        .i_rs           (i_rs),
        .i_byte         (i_byte),
        .o_busy         (o_busy),
        .o_lcd_rs       (o_lcd_rs),
        .o_lcd_e        (o_lcd_e),
        .o_lcd_data     (o_lcd_data),
        .o_logan_strobe (o_logan_strobe),
        .o_led_r        (o_led_r),
        .o_led_g        (o_led_g),
        .o_led_b        (o_led_b),
        .o_led0         (o_led0),
        .o_led1         (o_led1),
        .o_led2         (o_led2),
        .o_led3         (o_led3)
    );

    // ********************
    // helpers
    // ********************
    task automatic stop_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("MISMATCH %s exp %h got %h", name, exp, got);
            stop_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};              // one step per bit taken
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // lcd sees the high nybble then the low one with the same rs on both
    function automatic logic [9:0] expected_pair(input logic rs, input logic [7:0] b);
        return {rs, b[7:4], rs, b[3:0]};
    endfunction

    // ********************
    // monitor on the lcd pins and rgb
    // ********************
    always @(negedge clk) begin
        if (!i_reset) begin
            cycle = cycle + 1;
            check("{o_led_r,o_led_g,o_led_b} twice", 0,
                  32'({o_led_r, o_led_g, o_led_b} & prev_rgb));
            prev_rgb = {o_led_r, o_led_g, o_led_b};
            rgb_seen = rgb_seen | prev_rgb;
            if (o_lcd_e && !prev_e) begin           // rising edge
                if (cap_q.size() > 0 && cycle - rise_cycle < TCYCE) begin
                    $display("enable rose %0d cycles after the last rise", cycle - rise_cycle);
                    stop_run();
                end
                rise_cycle = cycle;
                held_rs    = o_lcd_rs;
                held_data  = o_lcd_data;
            end else if (o_lcd_e) begin             // pins must hold while e is high
                check("o_lcd_rs", 32'(held_rs), 32'(o_lcd_rs));
                check("o_lcd_data", 32'(held_data), 32'(o_lcd_data));
            end else if (prev_e) begin              // falling edge
                check("o_lcd_e width", PWEH, cycle - rise_cycle);
                cap_q.push_back({held_rs, held_data});
            end
            prev_e = o_lcd_e;
        end
    end

    // compare each captured nybble with the expected one
    always @(negedge clk) begin
        if (checked < cap_q.size()) begin
            if (checked >= exp_q.size()) begin
                $display("enable pulse seen with no byte outstanding");
                stop_run();
            end else begin
                check("o_lcd_rs", 32'(exp_q[checked][4]), 32'(cap_q[checked][4]));
                check("o_lcd_data", 32'(exp_q[checked][3:0]), 32'(cap_q[checked][3:0]));
                checked = checked + 1;
            end
        end
    end

    // ********************
    // stimulus
    // ********************
    task automatic send_byte(input bit meddle);
        logic [31:0] r;
        logic [9:0]  pair;
        logic        rs;
        int          n;
        rand_bits(8, r);
        i_byte.whole = r[7:0];
        rand_bits(1, r);
        rs   = r[0];
        pair = expected_pair(rs, i_byte.whole);
        exp_q.push_back(pair[9:5]);
        exp_q.push_back(pair[4:0]);
        i_rs  = rs;
        i_stb = 1'b1;
        @(negedge clk);
        i_stb = 1'b0;
        check("o_busy", 1, 32'(o_busy));
        n = 0;
        while (o_busy) begin
            if (meddle && (n == 4 || n == 60)) begin    // stray request that must be dropped
                rand_bits(8, r);
                i_byte.whole = r[7:0];
                i_rs  = ~rs;
                i_stb = 1'b1;
            end
            @(negedge clk);
            i_stb = 1'b0;
            n++;
            if (n > BYTE_TIMEOUT) timed_out("o_busy to fall after a byte");
        end
        check("enable pulses", exp_q.size(), cap_q.size());
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0]  start_leds;
        logic [3:0]  seen;
        int          n;
        lfsr         = SEED;
        i_reset      = 1'b1;
        i_button_n   = 1'b1;
        i_stb        = 1'b0;
        i_rs         = 1'b0;
        i_byte.whole = 8'h00;
        repeat (3) @(negedge clk);
        i_reset = 1'b0;

        // a request must vanish while locked
        rand_bits(8, r);
        i_byte.whole = r[7:0];
        i_stb = 1'b1;
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            i_stb = 1'b0;
            check("o_busy", 0, 32'(o_busy));
            check("o_lcd_e", 0, 32'(o_lcd_e));
            check("o_lcd_rs", 0, 32'(o_lcd_rs));
            check("o_lcd_data", 0, 32'(o_lcd_data));
            check("o_logan_strobe", 0, 32'(o_logan_strobe));
            check("o_led3..0", 32'hf, 32'({o_led3, o_led2, o_led1, o_led0}));
        end

        // strobe rises after two sync flops and the latch
        i_button_n = 1'b0;
        n = 0;
        while (!o_logan_strobe) begin
            @(negedge clk);
            n++;
            if (n > ARM_TIMEOUT) timed_out("o_logan_strobe to rise");
        end
        check("o_logan_strobe latency", 3, n);
        i_button_n = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check("o_logan_strobe", 1, 32'(o_logan_strobe));
        end

        // every led must move once armed
        start_leds = {o_led3, o_led2, o_led1, o_led0};
        seen = 4'b0000;
        n = 0;
        while (seen != 4'hf) begin
            @(negedge clk);
            seen = seen | ({o_led3, o_led2, o_led1, o_led0} ^ start_leds);
            n++;
            if (n > BLINK_TIMEOUT) timed_out("all four leds to toggle");
        end

        for (int i = 0; i < NUM_BYTES; i++) begin
            send_byte(i % 4 == 1);
        end

        check("{o_led_r,o_led_g,o_led_b} lit", 32'h7, 32'(rgb_seen));

        if (checked != exp_q.size() || cap_q.size() != 2 * NUM_BYTES) begin
            $display("%0d of %0d nybbles compared", checked, 2 * NUM_BYTES);
            stop_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* rtl/hd44780_top.sv */
`timescale 1ns/1ps

module hd44780_top import hd44780_pkg::*; #(
    parameter int TAS        = DEF_TAS,
    parameter int PWEH       = DEF_PWEH,
    parameter int TCYCE      = DEF_TCYCE,
    parameter int CNT_BITS   = DEF_CNT_BITS,
    parameter int BLINK_BITS = DEF_BLINK_BITS,
    parameter int PWM_BITS   = DEF_PWM_BITS
) (
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_button_n,
    input  logic      i_stb,            // byte request
    input  logic      i_rs,
    input  lcd_byte_u i_byte,
    output logic      o_busy,
    output logic      o_lcd_rs,         // lcd pins
    output logic      o_lcd_e,
    output nybble_t   o_lcd_data,
    output logic      o_logan_strobe,   // analyzer trigger
    output logic      o_led_r,
    output logic      o_led_g,
    output logic      o_led_b,
    output logic      o_led0,
    output logic      o_led1,
    output logic      o_led2,
    output logic      o_led3
);

    logic    armed;
    logic    core_reset;                // write path held until the button
    logic    nyb_stb;
    logic    nyb_rs;
    nybble_t nybble;
    logic    nyb_busy;

    assign core_reset = i_reset | ~armed;

    hd_button_arm u_arm (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_button_n     (i_button_n),
        .o_armed        (armed),
        .o_logan_strobe (o_logan_strobe)
    );

    // ********************
    // lcd write path
    // ********************
    hd_byte_sender u_byte (
        .clk        (clk),
        .i_reset    (core_reset),
        .i_stb      (i_stb),
        .i_rs       (i_rs),
        .i_byte     (i_byte),
        .i_nyb_busy (nyb_busy),
        .o_nyb_stb  (nyb_stb),
        .o_nyb_rs   (nyb_rs),
        .o_nybble   (nybble),
        .o_busy     (o_busy)
    );

    hd_nybble_sender #(
        .TAS      (TAS),
        .PWEH     (PWEH),
        .TCYCE    (TCYCE),
        .CNT_BITS (CNT_BITS)
    ) u_nyb (
        .clk        (clk),
        .i_reset    (core_reset),
        .i_stb      (nyb_stb),
        .i_rs       (nyb_rs),
        .i_nybble   (nybble),
        .o_busy     (nyb_busy),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_e    (o_lcd_e),
        .o_lcd_data (o_lcd_data)
    );

    // runs from plain reset so the rgb blink shows before arming
    hd_alive_blink #(
        .BLINK_BITS (BLINK_BITS),
        .PWM_BITS   (PWM_BITS)
    ) u_blink (
        .clk     (clk),
        .i_reset (i_reset),
        .i_armed (armed),
        .o_led_r (o_led_r),
        .o_led_g (o_led_g),
        .o_led_b (o_led_b),
        .o_led0  (o_led0),
        .o_led1  (o_led1),
        .o_led2  (o_led2),
        .o_led3  (o_led3)
    );

endmodule

/* rtl/hd_alive_blink.sv */
`timescale 1ns/1ps

module hd_alive_blink import hd44780_pkg::*; #(
    parameter int BLINK_BITS = DEF_BLINK_BITS,  // needs at least 4
    parameter int PWM_BITS   = DEF_PWM_BITS
) (
    input  logic clk,
    input  logic i_reset,
    input  logic i_armed,           // external leds stay dark until armed
    output logic o_led_r,           // rgb, active high
    output logic o_led_g,
    output logic o_led_b,
    output logic o_led0,            // external, active low
    output logic o_led1,
    output logic o_led2,
    output logic o_led3
);

    logic [BLINK_BITS-1:0] blink_cnt;   // free running
    logic [PWM_BITS-1:0]   pwm_cnt;     // dimming
    logic                  pwm_on;

    assign pwm_on = &pwm_cnt;           // 1 cycle in 2**PWM_BITS

    always_ff @(posedge clk) begin
        if (i_reset) begin
            blink_cnt <= '0;
            pwm_cnt   <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
            pwm_cnt   <= pwm_cnt + 1'b1;
        end
    end

    // ********************
    // rgb, green and blue alternate, red at twice the rate
    // ********************
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_led_r <= 1'b0;
            o_led_g <= 1'b0;
            o_led_b <= 1'b0;
        end else begin
            o_led_g <= pwm_on & ~blink_cnt[BLINK_BITS-1];
            o_led_b <= pwm_on &  blink_cnt[BLINK_BITS-1];
            o_led_r <= pwm_on & ~blink_cnt[BLINK_BITS-2];
        end
    end

    // external leds, low is lit
    always_ff @(posedge clk) begin
        if (i_reset || !i_armed) begin
            o_led0 <= 1'b1;
            o_led1 <= 1'b1;
            o_led2 <= 1'b1;
            o_led3 <= 1'b1;
        end else begin
            o_led0 <=  blink_cnt[BLINK_BITS-2];
            o_led1 <= ~blink_cnt[BLINK_BITS-3];
            o_led2 <=  blink_cnt[BLINK_BITS-3];
            o_led3 <= ~blink_cnt[BLINK_BITS-4];
        end
    end

endmodule

/* rtl/hd_nybble_sender.sv */
`timescale 1ns/1ps

module hd_nybble_sender import hd44780_pkg::*; #(
    parameter int TAS      = DEF_TAS,       // ticks, accept to e rise
    parameter int PWEH     = DEF_PWEH,      // ticks e stays high
    parameter int TCYCE    = DEF_TCYCE,     // ticks, accept to next possible accept
    parameter int CNT_BITS = DEF_CNT_BITS   // must hold TCYCE
) (
    input  logic    clk,
    input  logic    i_reset,
    input  logic    i_stb,          // one-cycle request, ignored while busy
    input  logic    i_rs,
    input  nybble_t i_nybble,
    output logic    o_busy,
    output logic    o_lcd_rs,       // r/w is tied low on the board
    output logic    o_lcd_e,
    output nybble_t o_lcd_data      // goes to lcd d7..d4
);

    // window bounds in counter units
    localparam logic [CNT_BITS-1:0] E_ON   = CNT_BITS'(TAS);
    localparam logic [CNT_BITS-1:0] E_OFF  = CNT_BITS'(TAS + PWEH);
    localparam logic [CNT_BITS-1:0] CYC_END = CNT_BITS'(TCYCE);

    logic [CNT_BITS-1:0] cnt;       // ticks since the accepting edge
    logic [CNT_BITS-1:0] cnt_nxt;
    logic                start;
    logic                run;
    logic                busy;
    logic                lcd_e;
    logic                lcd_rs;
    nybble_t             lcd_data;

    // ********************
    // tick counter
    // ********************
    assign start   = !busy && i_stb;
    assign run     = busy || start;
    // count after the coming edge, a new nybble restarts at 1
    assign cnt_nxt = busy ? cnt + 1'b1 : CNT_BITS'(1);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cnt   <= '0;
            busy  <= 1'b0;
            lcd_e <= 1'b0;
        end else if (run) begin
            cnt   <= cnt_nxt;
            busy  <= (cnt_nxt < CYC_END);                       // drops TCYCE after accept
            lcd_e <= (cnt_nxt >= E_ON) && (cnt_nxt < E_OFF);    // registered, no glitches on e
        end else begin
            lcd_e <= 1'b0;
        end
    end

    // ********************
    // pin latches
    // ********************
    // rs and data valid the cycle after accept, held through the whole cycle
    always_ff @(posedge clk) begin
        if (i_reset) begin
            lcd_rs   <= 1'b0;
            lcd_data <= '0;
        end else if (start) begin
            lcd_rs   <= i_rs;
            lcd_data <= i_nybble;
        end
    end

    assign o_busy     = busy;
    assign o_lcd_e    = lcd_e;
    assign o_lcd_rs   = lcd_rs;
    assign o_lcd_data = lcd_data;

endmodule

/* rtl/hd_byte_sender.sv */
`timescale 1ns/1ps

module hd_byte_sender import hd44780_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_stb,        // one-cycle request
    input  logic      i_rs,         // 0 command, 1 data
    input  lcd_byte_u i_byte,
    input  logic      i_nyb_busy,   // from nybble sender
    output logic      o_nyb_stb,
    output logic      o_nyb_rs,
    output nybble_t   o_nybble,
    output logic      o_busy        // high for the whole byte
);

    // sequencer states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HI   = 2'd1;  // high nybble handed off
    localparam logic [1:0] ST_LO   = 2'd2;  // low nybble handed off

    logic [1:0] state;
    logic       nyb_stb;            // registered strobe to the nybble sender
    logic       nyb_seen;           // nybble sender has gone busy for this nybble
    lcd_byte_u  byte_q;             // latched byte, payload only
    logic       rs_q;               // latched rs, payload only

    // ********************
    // sequencer
    // ********************
    // the nybble sender does all lcd timing, here we only wait for
    // its busy to rise and then fall before moving on
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= ST_IDLE;
            nyb_stb  <= 1'b0;
            nyb_seen <= 1'b0;
        end else begin
            nyb_stb <= 1'b0;                        // pulse by default
            case (state)
                ST_IDLE: begin
                    if (i_stb) begin                // only accepted when idle
                        nyb_stb  <= 1'b1;           // high nybble goes first
                        nyb_seen <= 1'b0;
                        state    <= ST_HI;
                    end
                end
                ST_HI: begin
                    if (i_nyb_busy) begin
                        nyb_seen <= 1'b1;
                    end else if (nyb_seen) begin    // high nybble done
                        nyb_stb  <= 1'b1;
                        nyb_seen <= 1'b0;
                        state    <= ST_LO;
                    end
                end
                ST_LO: begin
                    if (i_nyb_busy) begin
                        nyb_seen <= 1'b1;
                    end else if (nyb_seen) begin    // low nybble done, byte done
                        nyb_seen <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload latch on acceptance
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_stb) begin
            byte_q.whole <= i_byte.whole;
            rs_q         <= i_rs;
        end
    end

    assign o_nyb_stb = nyb_stb;
    assign o_nyb_rs  = rs_q;                        // same rs on both halves
    assign o_nybble  = (state == ST_LO) ? byte_q.nyb.lo : byte_q.nyb.hi;
    assign o_busy    = (state != ST_IDLE);          // rises the cycle after accept

endmodule

/* rtl/hd_button_arm.sv */
`timescale 1ns/1ps

module hd_button_arm (
    input  logic clk,
    input  logic i_reset,
    input  logic i_button_n,        // active low, pulled up on the board
    output logic o_armed,           // write path may run
    output logic o_logan_strobe     // to a pin, analyzer triggers on its rise
);

    logic btn_meta;                 // first sync flop
    logic btn_sync;                 // second sync flop, safe to use
    logic armed;                    // sticky, set on first press

    // ********************
    // synchronizer
    // ********************
    // held released in reset so a held button arms right after reset
    always_ff @(posedge clk) begin
        if (i_reset) begin
            btn_meta <= 1'b1;
            btn_sync <= 1'b1;
        end else begin
            btn_meta <= i_button_n;
            btn_sync <= btn_meta;
        end
    end

    // no debounce needed, the first low sample is all that counts
    always_ff @(posedge clk) begin
        if (i_reset) begin
            armed <= 1'b0;
        end else if (!btn_sync) begin
            armed <= 1'b1;          // stays set until reset
        end
    end

    assign o_armed        = armed;
    assign o_logan_strobe = armed;  // same level, separate pin

endmodule

/* rtl/hd44780_pkg.sv */
package hd44780_pkg;

    // ********************
    // lcd data types
    // ********************

    // one 4-bit bus transfer, the lcd only sees d7..d4 in 4-bit mode
    typedef logic [3:0] nybble_t;

    // byte to the lcd, seen whole or as the two nybbles it goes out as
    typedef union packed {
        logic [7:0] whole;          // as latched from the requester
        struct packed {
            nybble_t hi;            // sent first
            nybble_t lo;            // sent second
        } nyb;
    } lcd_byte_u;

    // ********************
    // nybble timing, in clock ticks
    // ********************

    // numbers below are for a 48 MHz clock, rounded up
    localparam int DEF_TAS      = 3;    // rs/data setup before e rises
    localparam int DEF_PWEH     = 22;   // e high width
    localparam int DEF_TCYCE    = 48;   // whole enable cycle, start to start
    localparam int DEF_CNT_BITS = 6;    // must hold DEF_TCYCE

    // ********************
    // alive blinker
    // ********************

    // top bit of 25 flips about every 0.35 s at 48 MHz
    localparam int DEF_BLINK_BITS = 25;
    // rgb on for 1 cycle in 2**3, they are far too bright at full duty
    localparam int DEF_PWM_BITS   = 3;

endpackage
